// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = bpred_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

# Sources from the file list plus the shared header
SOURCES  = $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Golden data is read at run time from the project root
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// File: sim.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/bpred_pkg.sv
verilog/bpred_ras.sv
verilog/bpred_ex.sv
verilog/bpred_fetch.sv
verilog/btb_writer.sv
verilog/btb_arbiter.sv
verilog/btb_mem.sv
verilog/bpred_top.sv
test/bpred_tb.sv

// File: test/bpred_golden.txt
# F pc kind exp_taken exp_target
# E kind pc taken target pred_taken pred_target exp_mispred exp_sel
# P is E fields then F fields, resolve and fetch issued together
# Values in hex, kind 0 none 1 branch 2 jal 3 call 4 jalr 5 ret
# Cold miss, then counter training on one branch
F 00000100 1 0 00000000
E 1 00000100 1 00000180 0 00000000 1 0
F 00000100 1 1 00000180
E 1 00000100 0 00000180 1 00000180 1 0
F 00000100 1 0 00000000
E 1 00000100 0 00000180 0 00000000 0 0
F 00000100 1 0 00000000
E 1 00000100 1 00000180 0 00000000 1 0
F 00000100 1 0 00000000
E 1 00000100 1 00000180 1 00000180 0 0
F 00000100 1 1 00000180
E 1 00000108 0 00000140 0 00000000 0 0
F 00000108 1 0 00000000
E 0 00000600 0 00000000 0 00000000 0 0
# Calls and returns through the RAS
F 00000210 3 0 00000000
F 00000300 5 1 00000214
F 00000304 5 0 00000000
F 00000220 3 0 00000000
F 00000230 3 0 00000000
F 00000310 5 1 00000234
F 00000314 5 1 00000224
E 3 00000210 1 00000400 0 00000000 0 0
F 00000210 3 1 00000400
F 00000320 5 1 00000214
# JALR redirects and never trains, JAL trains as taken
E 4 00000500 1 00000600 1 00000600 0 0
E 4 00000500 1 00000600 1 00000604 0 1
E 5 00000504 1 00000214 0 00000000 0 1
F 00000500 4 0 00000000
E 2 00000520 1 00000700 0 00000000 0 0
F 00000520 2 1 00000700
E 2 00000524 0 00000710 0 00000000 0 0
F 00000524 2 1 00000710
# Fetch racing a pending update
P 1 00000144 1 000001c0 0 00000000 1 0 00000100 1 1 00000180
F 00000144 1 1 000001c0
P 1 00000108 1 0000010c 0 00000000 1 0 00000108 1 1 0000010c

// File: test/bpred_tb.sv
`timescale 1ns/1ns
`include "bpred_params.svh"

module bpred_tb;
  import rv_pkg::*;

  localparam int XLEN = `BPRED_XLEN;
  // Cycle budget per golden record
  // A pending update plus a fetch needs about ten
  localparam int CYCLES_PER_RECORD = 20;

  logic             clk;
  logic             reset;
  logic             fetch_req;
  logic [XLEN-1:0]  fetch_pc;
  jb_kind_e         fetch_kind;
  logic             ex_valid;
  jb_kind_e         ex_kind;
  logic [XLEN-1:0]  ex_pc;
  logic             ex_taken;
  logic [XLEN-1:0]  ex_target;
  logic             ex_pred_taken;
  logic [XLEN-1:0]  ex_pred_target;
  logic             fetch_busy;
  logic             pred_valid;
  logic             pred_taken;
  logic [XLEN-1:0]  pred_target;
  logic             mispredicted;
  logic             pc_sel_jump;
  logic             ex_ready;

  int               fd;
  int               code;
  int               record_no;
  int               cycle_count = 0;
  int               cycle_limit;
  logic [7:0]       op;
  logic [8*200-1:0] line;
  // Resolve fields of a record
  logic [2:0]       r_kind;
  logic [XLEN-1:0]  r_pc;
  logic             r_taken;
  logic [XLEN-1:0]  r_target;
  logic             r_pred_taken;
  logic [XLEN-1:0]  r_pred_target;
  logic             r_mispred;
  logic             r_sel;
  // Fetch fields of a record
  logic [XLEN-1:0]  f_pc;
  logic [2:0]       f_kind;
  logic             f_taken;
  logic [XLEN-1:0]  f_target;

  bpred_top bpred_top_inst (
    .clk, .reset, .fetch_req, .fetch_pc, .fetch_kind,
    .ex_valid, .ex_kind, .ex_pc, .ex_taken, .ex_target,
    .ex_pred_taken, .ex_pred_target,
    .fetch_busy, .pred_valid, .pred_taken, .pred_target,
    .mispredicted, .pc_sel_jump, .ex_ready
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Limit grows as records are read
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: record %0d got no response before cycle %0d",
               record_no, cycle_limit);
      $display("sim failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: record %0d %s is %b, expected %b",
               $time, record_no, what, got, exp);
      $display("sim failed");
      $fatal(1, "bit compare failed");
    end
  endtask

  task automatic check_addr(input string what, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: record %0d %s is %h, expected %h",
               $time, record_no, what, got, exp);
      $display("sim failed");
      $fatal(1, "address compare failed");
    end
  endtask

  task automatic expect_fields(input int got, input int exp);
    if (got != exp) begin
      $display("Golden record %0d is malformed, read %0d of %0d fields",
               record_no, got, exp);
      $display("sim failed");
      $fatal(1, "bad golden record");
    end
  endtask

  // Branches and direct jumps train the BTB while a JALR never does
  function automatic logic trains_btb(input jb_kind_e kind);
    return (kind == JB_BRANCH) || (kind == JB_JAL) || (kind == JB_JAL_CALL);
  endfunction

  // Sample one step after the edge since ex_ready is registered
  task automatic wait_ready();
    while (!ex_ready) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic apply_resolve(input jb_kind_e kind, input logic [XLEN-1:0] pc,
                               input logic taken, input logic [XLEN-1:0] target,
                               input logic ptaken, input logic [XLEN-1:0] ptarget);
    ex_valid       = 1'b1;
    ex_kind        = kind;
    ex_pc          = pc;
    ex_taken       = taken;
    ex_target      = target;
    ex_pred_taken  = ptaken;
    ex_pred_target = ptarget;
  endtask

  // Flags are combinational and checked in the drive cycle
  task automatic check_resolve(input logic exp_mispred, input logic exp_sel);
    #1;
    check_bit("mispredicted", mispredicted, exp_mispred);
    check_bit("pc_sel_jump", pc_sel_jump, exp_sel);
  endtask

  task automatic apply_fetch(input logic [XLEN-1:0] pc, input jb_kind_e kind);
    fetch_req  = 1'b1;
    fetch_pc   = pc;
    fetch_kind = kind;
  endtask

  // Latency depends on arbitration, so follow pred_valid
  task automatic finish_fetch(input logic exp_taken, input logic [XLEN-1:0] exp_target);
    @(posedge clk);
    #1;
    fetch_req = 1'b0;
    ex_valid  = 1'b0;
    check_bit("fetch_busy", fetch_busy, 1'b1);
    while (!pred_valid) begin
      @(posedge clk);
      #1;
    end
    check_bit("pred_taken", pred_taken, exp_taken);
    check_addr("pred_target", pred_target, exp_target);
    // Response is a single-cycle pulse that frees the fetch side
    @(posedge clk);
    #1;
    check_bit("pred_valid", pred_valid, 1'b0);
    check_bit("fetch_busy", fetch_busy, 1'b0);
  endtask

  initial begin
    reset          = 1'b1;
    fetch_req      = 1'b0;
    fetch_pc       = '0;
    fetch_kind     = JB_NONE;
    ex_valid       = 1'b0;
    ex_kind        = JB_NONE;
    ex_pc          = '0;
    ex_taken       = 1'b0;
    ex_target      = '0;
    ex_pred_taken  = 1'b0;
    ex_pred_target = '0;
    record_no      = 0;
    // Margin for reset
    cycle_limit    = 10;
    fd = $fopen("test/bpred_golden.txt", "r");
    if (fd == 0) begin
      $display("Cannot open test/bpred_golden.txt");
      $display("sim failed");
      $fatal(1, "golden file missing");
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        code = $fgets(line, fd);
      end else begin
        record_no   = record_no + 1;
        cycle_limit = cycle_limit + CYCLES_PER_RECORD;
        case (op)
          "F": begin
            code = $fscanf(fd, "%h %h %h %h", f_pc, f_kind, f_taken, f_target);
            expect_fields(code, 4);
            @(posedge clk);
            #1;
            apply_fetch(f_pc, jb_kind_e'(f_kind));
            finish_fetch(f_taken, f_target);
          end
          "E": begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h", r_kind, r_pc, r_taken,
                           r_target, r_pred_taken, r_pred_target, r_mispred, r_sel);
            expect_fields(code, 8);
            @(posedge clk);
            #1;
            wait_ready();
            apply_resolve(jb_kind_e'(r_kind), r_pc, r_taken, r_target,
                          r_pred_taken, r_pred_target);
            check_resolve(r_mispred, r_sel);
            @(posedge clk);
            #1;
            ex_valid = 1'b0;
            // An accepted update holds off EX until it is written
            check_bit("ex_ready", ex_ready, !trains_btb(jb_kind_e'(r_kind)));
            wait_ready();
          end
          "P": begin
            // Resolve and fetch in the same cycle where the update takes the bus first
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", r_kind, r_pc,
                           r_taken, r_target, r_pred_taken, r_pred_target, r_mispred,
                           r_sel, f_pc, f_kind, f_taken, f_target);
            expect_fields(code, 12);
            @(posedge clk);
            #1;
            wait_ready();
            apply_resolve(jb_kind_e'(r_kind), r_pc, r_taken, r_target,
                          r_pred_taken, r_pred_target);
            apply_fetch(f_pc, jb_kind_e'(f_kind));
            check_resolve(r_mispred, r_sel);
            finish_fetch(f_taken, f_target);
            wait_ready();
          end
          default: begin
            $display("Golden record %0d has unknown operation %s", record_no, op);
            $display("sim failed");
            $fatal(1, "bad golden operation");
          end
        endcase
      end
    end
    $fclose(fd);
    if (record_no == 0) begin
      $display("Golden file holds no records");
      $display("sim failed");
      $fatal(1, "empty golden file");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// File: verilog/bpred_ex.sv
`timescale 1ns/1ns

module bpred_ex #(
  parameter int XLEN       = 32,
  parameter int BPRED      = 1,
  parameter int BTB_ENABLE = 1,
  parameter int RAS_ENABLE = 1
) (
  input  logic              ex_valid,
  input  rv_pkg::jb_kind_e  ex_kind,
  input  logic [XLEN-1:0]   ex_pc,
  input  logic              ex_taken,
  input  logic [XLEN-1:0]   ex_target,
  input  logic              ex_pred_taken,
  input  logic [XLEN-1:0]   ex_pred_target,
  output logic              mispredicted,
  output logic              pc_sel_jump,
  output logic              btb_update_en,
  output logic [XLEN-1:0]   btb_update_pc,
  output logic [XLEN-1:0]   btb_update_target,
  output logic              btb_update_taken
);
  import rv_pkg::*;

  logic is_branch;
  logic is_jump;
  logic is_jalr;

  // Instruction class qualified by a valid resolve
  assign is_branch = ex_valid && (ex_kind == JB_BRANCH);
  assign is_jump   = ex_valid && jb_is_jump(ex_kind);
  assign is_jalr   = ex_valid && jb_is_jalr(ex_kind);

  // Direction mismatch on conditional branches only
  if (BPRED != 0) begin : g_bpred
    assign mispredicted = is_branch && (ex_pred_taken != ex_taken);
  end else begin : g_no_bpred
    assign mispredicted = 1'b0;
  end

  if (BPRED != 0 && RAS_ENABLE != 0) begin : g_jalr_ras
    // JALR redirects when fetch had no target or guessed the wrong one
    assign pc_sel_jump = is_jalr &&
        (!ex_pred_taken || (ex_pred_target != ex_target));
  end else if (BPRED != 0) begin : g_jalr_no_ras
    // No RAS, so a JALR is never predicted
    assign pc_sel_jump = is_jalr;
  end else begin : g_no_jalr_pred
    assign pc_sel_jump = is_jump;
  end

  if (BTB_ENABLE != 0) begin : g_btb_update
    // Train on branches and direct jumps since a JALR target comes from a register
    assign btb_update_en     = is_branch || (is_jump && !is_jalr);
    assign btb_update_pc     = ex_pc;
    assign btb_update_target = ex_target;
    // JAL always counts as taken
    assign btb_update_taken  = is_jump ? 1'b1 : ex_taken;
  end else begin : g_no_btb_update
    assign btb_update_en     = 1'b0;
    assign btb_update_pc     = '0;
    assign btb_update_target = '0;
    assign btb_update_taken  = 1'b0;
  end

endmodule

// File: verilog/bpred_fetch.sv
`timescale 1ns/1ns
`include "bpred_params.svh"

module bpred_fetch (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fetch_req,
  input  logic [`BPRED_XLEN-1:0] fetch_pc,
  input  rv_pkg::jb_kind_e       fetch_kind,
  input  logic [`BPRED_XLEN-1:0] ras_top,
  input  logic                   ras_empty,
  input  logic                   wb_ack,
  input  logic [bpred_pkg::btb_rdata_width(`BPRED_XLEN)-1:0] wb_dat_r,
  output logic                   fetch_busy,
  output logic                   pred_valid,
  output logic                   pred_taken,
  output logic [`BPRED_XLEN-1:0] pred_target,
  output logic                   ras_push,
  output logic [`BPRED_XLEN-1:0] ras_push_addr,
  output logic                   ras_pop,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [`BPRED_XLEN-1:0] wb_adr
);
  import rv_pkg::*;
  import bpred_pkg::*;

  localparam int XLEN = `BPRED_XLEN;

  typedef enum logic [1:0] {
    FETCH_IDLE    = 2'd0,
    FETCH_BUS     = 2'd1,
    FETCH_RESPOND = 2'd2
  } fetch_state_e;

  fetch_state_e    state_q;
  logic            start;
  logic [XLEN-1:0] pc_q;
  logic            use_ras_q;
  logic [XLEN-1:0] ras_target_q;
  logic            btb_hit;
  ctr_e            btb_ctr;
  logic [XLEN-1:0] btb_target;

  // Requests arriving while busy are dropped
  assign start = fetch_req && (state_q == FETCH_IDLE);

  // RAS is touched at request time, return pops only a non-empty stack
  assign ras_push      = start && (fetch_kind == JB_JAL_CALL);
  assign ras_push_addr = fetch_pc + XLEN'(4);
  assign ras_pop       = start && (fetch_kind == JB_JALR_RET) && !ras_empty;

  // Unpack {hit, counter, target}
  assign btb_hit    = wb_dat_r[XLEN+2];
  assign btb_ctr    = ctr_e'(wb_dat_r[XLEN+1:XLEN]);
  assign btb_target = wb_dat_r[XLEN-1:0];

  // Read-only master
  assign wb_cyc = (state_q == FETCH_BUS);
  assign wb_stb = (state_q == FETCH_BUS);
  assign wb_we  = 1'b0;
  assign wb_adr = pc_q;

  assign fetch_busy = (state_q != FETCH_IDLE);
  assign pred_valid = (state_q == FETCH_RESPOND);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= FETCH_IDLE;
    end else begin
      case (state_q)
        FETCH_IDLE:    if (start) state_q <= FETCH_BUS;
        FETCH_BUS:     if (wb_ack) state_q <= FETCH_RESPOND;
        FETCH_RESPOND: state_q <= FETCH_IDLE;
        default:       state_q <= FETCH_IDLE;
      endcase
    end
  end

  // Lookup context, held through the bus phase
  always_ff @(posedge clk) begin
    if (start) begin
      pc_q         <= fetch_pc;
      use_ras_q    <= ras_pop;
      ras_target_q <= ras_top;
    end
  end

  // Return prediction overrides the BTB
  always_ff @(posedge clk) begin
    if (state_q == FETCH_BUS && wb_ack) begin
      if (use_ras_q) begin
        pred_taken  <= 1'b1;
        pred_target <= ras_target_q;
      end else if (btb_hit && ctr_taken(btb_ctr)) begin
        pred_taken  <= 1'b1;
        pred_target <= btb_target;
      end else begin
        pred_taken  <= 1'b0;
        pred_target <= '0;
      end
    end
  end

endmodule

// File: verilog/bpred_params.svh
`ifndef BPRED_PARAMS_SVH
`define BPRED_PARAMS_SVH

// Address and data width of the core
`define BPRED_XLEN 32

// BTB entry count, must be a power of two
`define BPRED_BTB_DEPTH 16

// Return address stack entries
`define BPRED_RAS_DEPTH 4

// Top-level defaults for the EX-side feature switches
`define BPRED_ENABLE 1
`define BPRED_BTB_ENABLE 1
`define BPRED_RAS_ENABLE 1

`endif

// File: verilog/bpred_pkg.sv
`include "bpred_params.svh"

package bpred_pkg;

  // 2-bit saturating direction counter, upper bit gives the direction
  typedef enum logic [1:0] {
    CTR_STRONG_NT = 2'd0,
    CTR_WEAK_NT   = 2'd1,
    CTR_WEAK_T    = 2'd2,
    CTR_STRONG_T  = 2'd3
  } ctr_e;

  // Which master currently owns the BTB bus
  typedef enum logic [1:0] {
    ARB_IDLE   = 2'd0,
    ARB_FETCH  = 2'd1,
    ARB_UPDATE = 2'd2
  } arb_owner_e;

  // One BTB line, tagged with the full PC
  typedef struct packed {
    logic                   valid;
    logic [`BPRED_XLEN-1:0] tag;
    logic [`BPRED_XLEN-1:0] target;
    ctr_e                   counter;
  } btb_entry_t;

  // Read data is {hit, counter, target}
  function automatic int btb_rdata_width(int xlen);
    return xlen + 3;
  endfunction

  function automatic logic ctr_taken(ctr_e c);
    return c[1];
  endfunction

  // Step one state toward the outcome, holding at either end
  function automatic ctr_e ctr_step(ctr_e c, logic taken);
    if (taken) begin
      return (c == CTR_STRONG_T) ? c : ctr_e'(c + 2'd1);
    end
    return (c == CTR_STRONG_NT) ? c : ctr_e'(c - 2'd1);
  endfunction

endpackage

// File: verilog/bpred_ras.sv
`timescale 1ns/1ns
`include "bpred_params.svh"

module bpred_ras #(
  parameter int DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   push,
  input  logic [`BPRED_XLEN-1:0] push_addr,
  input  logic                   pop,
  output logic [`BPRED_XLEN-1:0] top,
  output logic                   empty
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`BPRED_XLEN-1:0] stack [DEPTH];
  logic [PTR_W-1:0]       ptr_q;
  logic [CNT_W-1:0]       count_q;

  // ptr_q points at the next free slot
  assign top   = stack[ptr_q - PTR_W'(1)];
  assign empty = (count_q == '0);

  // Stack wraps on overflow, oldest entry is lost
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_q   <= '0;
      count_q <= '0;
    end else if (push) begin
      ptr_q <= ptr_q + PTR_W'(1);
      if (count_q != CNT_W'(DEPTH)) count_q <= count_q + CNT_W'(1);
    end else if (pop && !empty) begin
      ptr_q   <= ptr_q - PTR_W'(1);
      count_q <= count_q - CNT_W'(1);
    end
  end

  // Return addresses
  always_ff @(posedge clk) begin
    if (push) stack[ptr_q] <= push_addr;
  end

endmodule

// File: verilog/bpred_top.sv
`timescale 1ns/1ns
`include "bpred_params.svh"

module bpred_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fetch_req,
  input  logic [`BPRED_XLEN-1:0] fetch_pc,
  input  rv_pkg::jb_kind_e       fetch_kind,
  input  logic                   ex_valid,
  input  rv_pkg::jb_kind_e       ex_kind,
  input  logic [`BPRED_XLEN-1:0] ex_pc,
  input  logic                   ex_taken,
  input  logic [`BPRED_XLEN-1:0] ex_target,
  input  logic                   ex_pred_taken,
  input  logic [`BPRED_XLEN-1:0] ex_pred_target,
  output logic                   fetch_busy,
  output logic                   pred_valid,
  output logic                   pred_taken,
  output logic [`BPRED_XLEN-1:0] pred_target,
  output logic                   mispredicted,
  output logic                   pc_sel_jump,
  output logic                   ex_ready
);
  import bpred_pkg::*;

  localparam int XLEN = `BPRED_XLEN;
  localparam int RW   = btb_rdata_width(XLEN);

  // RAS hookup
  logic            ras_push;
  logic            ras_pop;
  logic            ras_empty;
  logic [XLEN-1:0] ras_push_addr;
  logic [XLEN-1:0] ras_top;
  // EX training request
  logic            upd_en;
  logic            upd_taken;
  logic [XLEN-1:0] upd_pc;
  logic [XLEN-1:0] upd_target;
  // Update master bus
  logic            upd_cyc;
  logic            upd_stb;
  logic            upd_we;
  logic            upd_ack;
  logic [XLEN-1:0] upd_adr;
  logic [XLEN:0]   upd_dat_w;
  // Fetch master bus
  logic            fet_cyc;
  logic            fet_stb;
  logic            fet_we;
  logic            fet_ack;
  logic [XLEN-1:0] fet_adr;
  logic [RW-1:0]   fet_dat_r;
  // Memory side
  logic            mem_cyc;
  logic            mem_stb;
  logic            mem_we;
  logic            mem_ack;
  logic [XLEN-1:0] mem_adr;
  logic [XLEN:0]   mem_dat_w;
  logic [RW-1:0]   mem_dat_r;

  bpred_fetch bpred_fetch_inst (
    .clk, .reset, .fetch_req, .fetch_pc, .fetch_kind,
    .ras_top, .ras_empty,
    .wb_ack(fet_ack), .wb_dat_r(fet_dat_r),
    .fetch_busy, .pred_valid, .pred_taken, .pred_target,
    .ras_push, .ras_push_addr, .ras_pop,
    .wb_cyc(fet_cyc), .wb_stb(fet_stb), .wb_we(fet_we), .wb_adr(fet_adr)
  );

  bpred_ras #(.DEPTH(`BPRED_RAS_DEPTH)) bpred_ras_inst (
    .clk, .reset, .push(ras_push), .push_addr(ras_push_addr), .pop(ras_pop),
    .top(ras_top), .empty(ras_empty)
  );

  bpred_ex #(
    .XLEN(XLEN), .BPRED(`BPRED_ENABLE),
    .BTB_ENABLE(`BPRED_BTB_ENABLE), .RAS_ENABLE(`BPRED_RAS_ENABLE)
  ) bpred_ex_inst (
    .ex_valid, .ex_kind, .ex_pc, .ex_taken, .ex_target,
    .ex_pred_taken, .ex_pred_target,
    .mispredicted, .pc_sel_jump,
    .btb_update_en(upd_en), .btb_update_pc(upd_pc),
    .btb_update_target(upd_target), .btb_update_taken(upd_taken)
  );

  btb_writer btb_writer_inst (
    .clk, .reset,
    .btb_update_en(upd_en), .btb_update_pc(upd_pc),
    .btb_update_target(upd_target), .btb_update_taken(upd_taken),
    .ex_valid, .wb_ack(upd_ack), .ex_ready,
    .wb_cyc(upd_cyc), .wb_stb(upd_stb), .wb_we(upd_we),
    .wb_adr(upd_adr), .wb_dat_w(upd_dat_w)
  );

  btb_arbiter btb_arbiter_inst (
    .clk, .reset,
    .m0_cyc(upd_cyc), .m0_stb(upd_stb), .m0_we(upd_we), .m0_adr(upd_adr),
    .m0_dat_w(upd_dat_w), .m0_ack(upd_ack),
    .m1_cyc(fet_cyc), .m1_stb(fet_stb), .m1_we(fet_we), .m1_adr(fet_adr),
    .m1_ack(fet_ack), .m1_dat_r(fet_dat_r),
    .s_cyc(mem_cyc), .s_stb(mem_stb), .s_we(mem_we), .s_adr(mem_adr),
    .s_dat_w(mem_dat_w), .s_ack(mem_ack), .s_dat_r(mem_dat_r)
  );

  btb_mem #(.DEPTH(`BPRED_BTB_DEPTH), .XLEN(XLEN)) btb_mem_inst (
    .clk, .reset, .cyc(mem_cyc), .stb(mem_stb), .we(mem_we),
    .adr(mem_adr), .dat_w(mem_dat_w), .ack(mem_ack), .dat_r(mem_dat_r)
  );

endmodule

// File: verilog/btb_arbiter.sv
`timescale 1ns/1ns
`include "bpred_params.svh"

module btb_arbiter (
  input  logic                   clk,
  input  logic                   reset,
  // Update master with higher priority
  input  logic                   m0_cyc,
  input  logic                   m0_stb,
  input  logic                   m0_we,
  input  logic [`BPRED_XLEN-1:0] m0_adr,
  input  logic [`BPRED_XLEN:0]   m0_dat_w,
  output logic                   m0_ack,
  // Read-only fetch master
  input  logic                   m1_cyc,
  input  logic                   m1_stb,
  input  logic                   m1_we,
  input  logic [`BPRED_XLEN-1:0] m1_adr,
  output logic                   m1_ack,
  output logic [bpred_pkg::btb_rdata_width(`BPRED_XLEN)-1:0] m1_dat_r,
  // BTB memory
  output logic                   s_cyc,
  output logic                   s_stb,
  output logic                   s_we,
  output logic [`BPRED_XLEN-1:0] s_adr,
  output logic [`BPRED_XLEN:0]   s_dat_w,
  input  logic                   s_ack,
  input  logic [bpred_pkg::btb_rdata_width(`BPRED_XLEN)-1:0] s_dat_r
);
  import bpred_pkg::*;

  arb_owner_e owner_q;
  arb_owner_e owner;

  // Grant on the same cycle from idle and release when the owner drops cyc
  always_comb begin
    owner = owner_q;
    case (owner_q)
      ARB_IDLE: begin
        if (m0_cyc) owner = ARB_UPDATE;
        else if (m1_cyc) owner = ARB_FETCH;
      end
      ARB_UPDATE: if (!m0_cyc) owner = ARB_IDLE;
      ARB_FETCH:  if (!m1_cyc) owner = ARB_IDLE;
      default:    owner = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) owner_q <= ARB_IDLE;
    else owner_q <= owner;
  end

  // Forward the granted master and nothing while idle
  always_comb begin
    s_cyc   = 1'b0;
    s_stb   = 1'b0;
    s_we    = 1'b0;
    s_adr   = '0;
    s_dat_w = '0;
    if (owner == ARB_UPDATE) begin
      s_cyc   = m0_cyc;
      s_stb   = m0_stb;
      s_we    = m0_we;
      s_adr   = m0_adr;
      s_dat_w = m0_dat_w;
    end else if (owner == ARB_FETCH) begin
      s_cyc = m1_cyc;
      s_stb = m1_stb;
      s_we  = m1_we;
      s_adr = m1_adr;
    end
  end

  // Ungranted master sees no ack and keeps waiting
  assign m0_ack   = s_ack && (owner == ARB_UPDATE);
  assign m1_ack   = s_ack && (owner == ARB_FETCH);
  assign m1_dat_r = (owner == ARB_FETCH) ? s_dat_r : '0;

  // Every memory ack reaches exactly one master
  a_one_ack: assert property (@(posedge clk) disable iff (reset)
    s_ack |-> (m0_ack ^ m1_ack));

endmodule

// File: verilog/btb_mem.sv
`timescale 1ns/1ns

module btb_mem #(
  parameter int DEPTH = 16,
  parameter int XLEN  = 32
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            cyc,
  input  logic            stb,
  input  logic            we,
  input  logic [XLEN-1:0] adr,
  input  logic [XLEN:0]   dat_w,
  output logic            ack,
  output logic [bpred_pkg::btb_rdata_width(XLEN)-1:0] dat_r
);
  import bpred_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  btb_entry_t       entries [DEPTH];
  btb_entry_t       cur;
  logic [IDX_W-1:0] idx;
  logic             hit;
  logic             req;
  logic             wr_taken;

  // Instructions are word aligned, so skip the low two bits
  assign idx = adr[IDX_W+1:2];
  assign cur = entries[idx];
  assign hit = cur.valid && (cur.tag == adr);

  // New strobe only, the ack cycle must not repeat the access
  assign req      = cyc && stb && !ack;
  assign wr_taken = dat_w[XLEN];

  always_ff @(posedge clk) begin
    if (reset) ack <= 1'b0;
    else ack <= req;
  end

  always_ff @(posedge clk) begin
    if (req && !we) dat_r <= {hit, cur.counter, cur.target};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) entries[i].valid <= 1'b0;
    end else if (req && we) begin
      if (hit) begin
        // Train the existing line
        entries[idx].counter <= ctr_step(cur.counter, wr_taken);
        entries[idx].target  <= dat_w[XLEN-1:0];
      end else begin
        // Allocate, start weak in the observed direction
        entries[idx].valid   <= 1'b1;
        entries[idx].tag     <= adr;
        entries[idx].target  <= dat_w[XLEN-1:0];
        entries[idx].counter <= wr_taken ? CTR_WEAK_T : CTR_WEAK_NT;
      end
    end
  end

endmodule

// File: verilog/btb_writer.sv
`timescale 1ns/1ns
`include "bpred_params.svh"

module btb_writer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   btb_update_en,
  input  logic [`BPRED_XLEN-1:0] btb_update_pc,
  input  logic [`BPRED_XLEN-1:0] btb_update_target,
  input  logic                   btb_update_taken,
  input  logic                   ex_valid,
  input  logic                   wb_ack,
  output logic                   ex_ready,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [`BPRED_XLEN-1:0] wb_adr,
  output logic [`BPRED_XLEN:0]   wb_dat_w
);
  logic                   pending_q;
  logic                   accept;
  logic [`BPRED_XLEN-1:0] target_q;
  logic                   taken_q;

  // Only one update in flight, EX stalls behind it
  assign ex_ready = !pending_q;
  assign accept   = ex_valid && ex_ready && btb_update_en;

  assign wb_cyc   = pending_q;
  assign wb_stb   = pending_q;
  assign wb_we    = 1'b1;
  assign wb_dat_w = {taken_q, target_q};

  always_ff @(posedge clk) begin
    if (reset) pending_q <= 1'b0;
    else if (accept) pending_q <= 1'b1;
    else if (wb_ack) pending_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wb_adr   <= btb_update_pc;
      target_q <= btb_update_target;
      taken_q  <= btb_update_taken;
    end
  end

  // Classic cycle, request held until acknowledged
  a_stb_until_ack: assert property (@(posedge clk) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb);

endmodule

// File: verilog/rv_pkg.sv
package rv_pkg;

  // Control-flow class of an instruction, supplied by decode
  // Call and return follow the link-register hint (rd/rs1 = x1 or x5)
  typedef enum logic [2:0] {
    JB_NONE     = 3'd0,
    JB_BRANCH   = 3'd1,
    JB_JAL      = 3'd2,
    JB_JAL_CALL = 3'd3,
    JB_JALR     = 3'd4,
    JB_JALR_RET = 3'd5
  } jb_kind_e;

  // Any unconditional jump, direct or indirect
  function automatic logic jb_is_jump(jb_kind_e kind);
    return (kind == JB_JAL) || (kind == JB_JAL_CALL) ||
           (kind == JB_JALR) || (kind == JB_JALR_RET);
  endfunction

  // Register-indirect jump, target not known at fetch
  function automatic logic jb_is_jalr(jb_kind_e kind);
    return (kind == JB_JALR) || (kind == JB_JALR_RET);
  endfunction

endpackage
